// ==== llm_int_pkg.sv ====
package llm_int_pkg;

    // ************************************************************
    // sizes
    // ************************************************************

    localparam int VEC_LEN = 4;                        // vector length and matrix dimension
    localparam int FULL_W = 16;                        // full-precision element width
    localparam int QUANT_W = 8;                        // quantized element width
    localparam int QUANT_SHIFT = FULL_W - QUANT_W;     // low bits dropped by quantization
    localparam int ROW_W = 2;                          // enough for VEC_LEN rows

    // accumulator holds a full x full product sum of VEC_LEN terms
    localparam int ACC_W = 2 * FULL_W + 2;

    // ************************************************************
    // outlier rule
    // ************************************************************

    localparam int HIGH_SLOTS = 2;                     // elements kept at full precision
    localparam int OUTLIER_THRESHOLD = 4096;           // |x| above this is a candidate

    // ************************************************************
    // types
    // ************************************************************

    typedef logic signed [FULL_W-1:0] full_t;          // one full-precision element
    typedef logic signed [QUANT_W-1:0] quant_t;        // one quantized element
    typedef logic signed [ACC_W-1:0] acc_t;            // one accumulated result
    typedef logic [ROW_W-1:0] row_t;                   // one row index

    // controller states, one vector in flight
    typedef enum logic [2:0] {
        IDLE,                                          // waiting for weights or data
        SCATTER,                                       // lanes sit in the scatter registers
        MAC,                                           // one row per cycle
        DRAIN,                                         // output register loads
        HOLD                                           // result offered on data_out
    } ctrl_state_t;

endpackage

// ==== outlier_scatter.sv ====
`timescale 1ns/1ps

module outlier_scatter
    import llm_int_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  full_t [VEC_LEN-1:0]       data_in,
    input  logic                      in_accept,
    output full_t [VEC_LEN-1:0]       high_lane,
    output quant_t [VEC_LEN-1:0]      low_lane
);

    logic [VEC_LEN-1:0] is_outlier;                    // magnitude over threshold
    full_t [VEC_LEN-1:0] high_next;
    quant_t [VEC_LEN-1:0] low_next;

    always_comb begin
        for (int i = 0; i < VEC_LEN; i++) begin
            is_outlier[i] = (data_in[i] > OUTLIER_THRESHOLD) ||
                            (data_in[i] < -OUTLIER_THRESHOLD);
        end
    end

    // first HIGH_SLOTS candidates from index 0 stay at full precision
    always_comb begin
        int taken;
        taken = 0;
        for (int i = 0; i < VEC_LEN; i++) begin
            if (is_outlier[i] && (taken < HIGH_SLOTS)) begin
                high_next[i] = data_in[i];
                low_next[i] = '0;
                taken = taken + 1;
            end else begin
                high_next[i] = '0;
                low_next[i] = quant_t'(data_in[i] >>> QUANT_SHIFT);   // keep sign, drop low bits
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            high_lane <= '0;
            low_lane <= '0;
        end else if (in_accept) begin
            high_lane <= high_next;
            low_lane <= low_next;
        end
    end

    // ************************************************************
    // checks
    // ************************************************************

    function automatic int count_nonzero(full_t [VEC_LEN-1:0] lane);
        int n;
        n = 0;
        for (int i = 0; i < VEC_LEN; i++) begin
            if (lane[i] != '0) begin
                n = n + 1;
            end
        end
        return n;
    endfunction

    // the full-precision lane never carries more than its slots
    a_high_slots : assert property (
        @(posedge clk) disable iff (!rst_n)
        count_nonzero(high_lane) <= HIGH_SLOTS
    );

endmodule

// ==== weight_store.sv ====
`timescale 1ns/1ps

module weight_store
    import llm_int_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  full_t [VEC_LEN*VEC_LEN-1:0]       weights,        // row-major
    input  logic                              weight_load,
    output full_t [VEC_LEN*VEC_LEN-1:0]       full_weights,
    output quant_t [VEC_LEN*VEC_LEN-1:0]      quant_weights,
    output logic                              weights_loaded
);

    full_t [VEC_LEN*VEC_LEN-1:0] full_q;
    quant_t [VEC_LEN*VEC_LEN-1:0] quant_q;
    quant_t [VEC_LEN*VEC_LEN-1:0] quant_next;

    // same arithmetic shift as the data path quantizer
    always_comb begin
        for (int i = 0; i < VEC_LEN * VEC_LEN; i++) begin
            quant_next[i] = quant_t'(weights[i] >>> QUANT_SHIFT);
        end
    end

    // ************************************************************
    // matrix copies
    // ************************************************************

    always_ff @(posedge clk) begin
        if (weight_load) begin
            full_q <= weights;
            quant_q <= quant_next;
        end
    end

    // sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weights_loaded <= 1'b0;
        end else if (weight_load) begin
            weights_loaded <= 1'b1;
        end
    end

    assign full_weights = full_q;
    assign quant_weights = quant_q;

endmodule

// ==== row_mac.sv ====
`timescale 1ns/1ps

module row_mac
    import llm_int_pkg::*;
#(
    parameter int ELEM_W = FULL_W,                     // lane element width
    parameter int WGT_W = FULL_W                       // weight element width
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic [VEC_LEN-1:0][ELEM_W-1:0]            lane,
    input  logic [VEC_LEN*VEC_LEN-1:0][WGT_W-1:0]     weights,   // row-major
    input  row_t                                      row_sel,
    input  logic                                      row_en,
    output acc_t [VEC_LEN-1:0]                        acc
);

    acc_t row_sum;                                     // dot product of selected row

    // ************************************************************
    // one row against the lane
    // ************************************************************

    always_comb begin
        acc_t term;
        int base;
        row_sum = '0;
        base = int'(row_sel) * VEC_LEN;
        for (int c = 0; c < VEC_LEN; c++) begin
            term = $signed(lane[c]) * $signed(weights[base + c]);   // sign-extended to ACC_W
            row_sum = row_sum + term;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (row_en) begin
            acc[row_sel] <= row_sum;                   // only the walked row changes
        end
    end

endmodule

// ==== mixed_gather.sv ====
`timescale 1ns/1ps

module mixed_gather
    import llm_int_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  acc_t [VEC_LEN-1:0]    high_acc,
    input  acc_t [VEC_LEN-1:0]    low_acc,
    input  logic                  out_load,
    output acc_t [VEC_LEN-1:0]    data_out
);

    acc_t [VEC_LEN-1:0] mixed;

    // ************************************************************
    // rescale and sum
    // ************************************************************

    // both operands of the low product lost QUANT_SHIFT bits, so scale by twice that
    always_comb begin
        for (int i = 0; i < VEC_LEN; i++) begin
            mixed[i] = high_acc[i] + (low_acc[i] <<< (2 * QUANT_SHIFT));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out <= '0;                            // zero until first result
        end else if (out_load) begin
            data_out <= mixed;
        end
    end

endmodule

// ==== linear_ctrl.sv ====
`timescale 1ns/1ps

module linear_ctrl
    import llm_int_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  weight_valid,
    output logic  weight_ready,
    input  logic  data_in_valid,
    output logic  data_in_ready,
    input  logic  data_out_ready,
    output logic  data_out_valid,
    input  logic  weights_loaded,
    output logic  weight_load,
    output logic  in_accept,
    output row_t  row_sel,
    output logic  row_en,
    output logic  out_load
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    row_t row_cnt;                                     // row being accumulated in MAC

    // ************************************************************
    // state register and row counter
    // ************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt <= '0;
        end else if (state == MAC) begin
            row_cnt <= row_cnt + row_t'(1);            // wraps to 0 after the last row
        end else begin
            row_cnt <= '0;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (in_accept) begin
                    state_next = SCATTER;
                end
            end
            SCATTER: state_next = MAC;
            MAC: begin
                if (row_cnt == row_t'(VEC_LEN - 1)) begin
                    state_next = DRAIN;
                end
            end
            DRAIN: state_next = HOLD;
            HOLD: begin
                if (data_out_ready) begin
                    state_next = IDLE;         // next vector can be taken a cycle later
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // ************************************************************
    // handshakes and datapath strobes
    // ************************************************************

    assign weight_ready = (state == IDLE);
    assign data_in_ready = (state == IDLE) && weights_loaded;
    assign data_out_valid = (state == HOLD);

    assign weight_load = weight_valid && weight_ready;
    assign in_accept = data_in_valid && data_in_ready;
    assign row_sel = row_cnt;
    assign row_en = (state == MAC);
    assign out_load = (state == DRAIN);

    a_no_overlap : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(data_in_ready && data_out_valid)
    );

    a_row_en_in_mac : assert property (
        @(posedge clk) disable iff (!rst_n)
        row_en |-> (state == MAC)
    );

    // result is offered a fixed latency after the data transfer
    // and is first sampled high one edge after the output register loads
    a_latency : assert property (
        @(posedge clk) disable iff (!rst_n)
        in_accept |-> ##(VEC_LEN + 3) (data_out_valid && !$past(data_out_valid))
    );

endmodule

// ==== llm_int_linear.sv ====
`timescale 1ns/1ps

module llm_int_linear
    import llm_int_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  full_t [VEC_LEN*VEC_LEN-1:0]       weights,        // row-major
    input  logic                              weight_valid,
    output logic                              weight_ready,
    input  full_t [VEC_LEN-1:0]               data_in,
    input  logic                              data_in_valid,
    output logic                              data_in_ready,
    output acc_t [VEC_LEN-1:0]                data_out,
    output logic                              data_out_valid,
    input  logic                              data_out_ready
);

    full_t [VEC_LEN*VEC_LEN-1:0] full_weights;
    quant_t [VEC_LEN*VEC_LEN-1:0] quant_weights;
    logic weights_loaded;
    logic weight_load;
    logic in_accept;
    row_t row_sel;
    logic row_en;
    logic out_load;
    full_t [VEC_LEN-1:0] high_lane;                    // outliers at full precision
    quant_t [VEC_LEN-1:0] low_lane;                    // everything else, 8 bit
    acc_t [VEC_LEN-1:0] high_acc;
    acc_t [VEC_LEN-1:0] low_acc;

    // ************************************************************
    // control
    // ************************************************************

    linear_ctrl ctrl_i (
        .clk(clk), .rst_n(rst_n),
        .weight_valid(weight_valid), .weight_ready(weight_ready),
        .data_in_valid(data_in_valid), .data_in_ready(data_in_ready),
        .data_out_ready(data_out_ready), .data_out_valid(data_out_valid),
        .weights_loaded(weights_loaded), .weight_load(weight_load),
        .in_accept(in_accept), .row_sel(row_sel), .row_en(row_en), .out_load(out_load)
    );

    // ************************************************************
    // datapath
    // ************************************************************

    weight_store store_i (
        .clk(clk), .rst_n(rst_n), .weights(weights), .weight_load(weight_load),
        .full_weights(full_weights), .quant_weights(quant_weights),
        .weights_loaded(weights_loaded)
    );

    outlier_scatter scatter_i (
        .clk(clk), .rst_n(rst_n), .data_in(data_in), .in_accept(in_accept),
        .high_lane(high_lane), .low_lane(low_lane)
    );

    row_mac #(.ELEM_W(FULL_W), .WGT_W(FULL_W)) high_mac (
        .clk(clk), .rst_n(rst_n), .lane(high_lane), .weights(full_weights),
        .row_sel(row_sel), .row_en(row_en), .acc(high_acc)
    );

    row_mac #(.ELEM_W(QUANT_W), .WGT_W(QUANT_W)) low_mac (
        .clk(clk), .rst_n(rst_n), .lane(low_lane), .weights(quant_weights),
        .row_sel(row_sel), .row_en(row_en), .acc(low_acc)
    );

    mixed_gather gather_i (
        .clk(clk), .rst_n(rst_n), .high_acc(high_acc), .low_acc(low_acc),
        .out_load(out_load), .data_out(data_out)
    );

endmodule

// ==== tb_llm_int_linear.sv ====
`timescale 1ns/1ps

module tb_llm_int_linear
    import llm_int_pkg::*;
();

    localparam int NUM_VECTORS = 40;
    localparam int MAX_STALL = 8;                      // longest hold of data_out_ready low
    localparam int TIMEOUT_CYCLES = NUM_VECTORS * (VEC_LEN + 2 + MAX_STALL) + 200;
    localparam logic [31:0] SEED = 32'h0844_5b01;

    logic clk;
    logic rst_n;
    full_t [VEC_LEN*VEC_LEN-1:0] weights;
    logic weight_valid;
    logic weight_ready;
    full_t [VEC_LEN-1:0] data_in;
    logic data_in_valid;
    logic data_in_ready;
    acc_t [VEC_LEN-1:0] data_out;
    logic data_out_valid;
    logic data_out_ready;

    logic [31:0] lcg_state;
    longint model_w [VEC_LEN*VEC_LEN];                 // matrix as the DUT last accepted it
    longint expect_q [$];                              // VEC_LEN entries per vector in flight
    acc_t [VEC_LEN-1:0] held_out;
    logic held_valid;
    int cycle_cnt;
    int accept_cycle;
    int check_cnt;
    int error_cnt;
    int vec_done;
    int none_cnt;
    int few_cnt;
    int many_cnt;

    llm_int_linear llm_int_linear_i (
        .clk(clk), .rst_n(rst_n),
        .weights(weights), .weight_valid(weight_valid), .weight_ready(weight_ready),
        .data_in(data_in), .data_in_valid(data_in_valid), .data_in_ready(data_in_ready),
        .data_out(data_out), .data_out_valid(data_out_valid), .data_out_ready(data_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ************************************************************
    // random numbers and stimulus
    // ************************************************************

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // kind 0 small, 1 medium, 2 full range
    function automatic full_t pick_element(input int kind);
        logic [31:0] r;
        full_t v;
        r = next_random();
        case (kind)
            0: v = full_t'(r[23:16]);                  // below 256
            1: v = full_t'(r[27:16]);                  // never above the threshold
            default: v = full_t'(r[31:16]);
        endcase
        if (kind < 2 && r[31]) begin
            v = -v;
        end
        return v;
    endfunction

    task automatic drive_random_weights();
        for (int i = 0; i < VEC_LEN * VEC_LEN; i++) begin
            weights[i] = pick_element(int'(next_random() % 3));
        end
    endtask

    task automatic drive_random_vector();
        logic [31:0] r;
        int kind;
        r = next_random();
        for (int c = 0; c < VEC_LEN; c++) begin
            case (r[31:30])
                2'd0: kind = 1;                        // no outliers at all
                2'd1: kind = r[c+20] ? 2 : 0;          // small or large per element
                2'd2: kind = 2;                        // mostly three or four outliers
                default: kind = r[c+20] ? 2 : 1;
            endcase
            data_in[c] = pick_element(kind);
        end
    endtask

    task automatic load_weights();
        drive_random_weights();
        weight_valid = 1'b1;
        while (!weight_ready) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        weight_valid = 1'b0;
    endtask

    // with_weights puts a new matrix on the same edge as the data
    task automatic send_vector(input bit with_weights);
        drive_random_vector();
        data_in_valid = 1'b1;
        if (with_weights) begin
            drive_random_weights();
            weight_valid = 1'b1;
        end
        while (!data_in_ready) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        data_in_valid = 1'b0;
        weight_valid = 1'b0;
    endtask

    task automatic collect_result();
        int stall;
        while (!data_out_valid) begin
            @(posedge clk);
            #2;
        end
        stall = int'(next_random() % (MAX_STALL + 1));
        repeat (stall) begin
            @(posedge clk);
            #2;
        end
        data_out_ready = 1'b1;
        @(posedge clk);
        #2;
        data_out_ready = 1'b0;
    endtask

    // ************************************************************
    // reference model and checks
    // ************************************************************

    task automatic predict_vector(input full_t [VEC_LEN-1:0] vec);
        longint hi [VEC_LEN];
        longint lo [VEC_LEN];
        longint x;
        longint sum_hi;
        longint sum_lo;
        int taken;
        int cand;
        taken = 0;
        cand = 0;
        for (int c = 0; c < VEC_LEN; c++) begin
            x = longint'(vec[c]);
            hi[c] = 0;
            lo[c] = x >>> QUANT_SHIFT;                 // quantized unless kept below
            if (x > OUTLIER_THRESHOLD || x < -OUTLIER_THRESHOLD) begin
                cand++;
                if (taken < HIGH_SLOTS) begin
                    hi[c] = x;
                    lo[c] = 0;
                    taken++;
                end
            end
        end
        if (cand == 0) begin
            none_cnt++;
        end else if (cand <= HIGH_SLOTS) begin
            few_cnt++;
        end else begin
            many_cnt++;
        end
        for (int r = 0; r < VEC_LEN; r++) begin
            sum_hi = 0;
            sum_lo = 0;
            for (int c = 0; c < VEC_LEN; c++) begin
                sum_hi += hi[c] * model_w[r*VEC_LEN+c];
                sum_lo += lo[c] * (model_w[r*VEC_LEN+c] >>> QUANT_SHIFT);
            end
            expect_q.push_back(sum_hi + (sum_lo <<< (2 * QUANT_SHIFT)));
        end
    endtask

    task automatic compare_value(input string what, input int idx,
                                 input longint got, input longint exp);
        check_cnt++;
        assert (got == exp) else begin
            error_cnt++;
            $display("error %0t: %s[%0d] is %0d, expected %0d", $time, what, idx, got, exp);
        end
    endtask

    task automatic check_output();
        longint exp;
        if (expect_q.size() < VEC_LEN) begin
            error_cnt++;
            $display("output transfer at %0t with no prediction pending", $time);
        end else begin
            for (int r = 0; r < VEC_LEN; r++) begin
                exp = expect_q.pop_front();
                compare_value("data_out", r, longint'(data_out[r]), exp);
            end
        end
        vec_done++;
    endtask

    task automatic finish_run(input bit timed_out);
        $display("summary: %0d vectors, %0d checks, %0d errors", vec_done, check_cnt, error_cnt);
        if (!timed_out && error_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    // sampled mid-cycle, a transfer seen here happens on the next rising edge
    always @(negedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            finish_run(1'b1);
        end else if (rst_n) begin
            if (weight_valid && weight_ready) begin
                for (int i = 0; i < VEC_LEN * VEC_LEN; i++) begin
                    model_w[i] = longint'(weights[i]);
                end
            end
            if (data_in_valid && data_in_ready) begin
                predict_vector(data_in);               // sees a same-edge matrix first
                accept_cycle = cycle_cnt + 1;          // count of the first negedge after the transfer
            end
            if (data_out_valid) begin
                check_cnt++;
                assert (!data_in_ready && !weight_ready) else begin
                    error_cnt++;
                    $display("error %0t: a ready output is high while a result is held", $time);
                end
                if (held_valid) begin
                    check_cnt++;
                    assert (data_out == held_out) else begin
                        error_cnt++;
                        $display("error %0t: data_out changed before the output transfer",
                                 $time);
                    end
                end else begin
                    compare_value("latency", 0, cycle_cnt - accept_cycle, VEC_LEN + 2);
                end
                if (data_out_ready) begin
                    check_output();
                end
            end
            held_valid = data_out_valid && !data_out_ready;
            held_out = data_out;
        end
    end

    // ************************************************************
    // test sequence
    // ************************************************************

    initial begin
        rst_n = 1'b0;
        weights = '0;
        weight_valid = 1'b0;
        data_in = '0;
        data_in_valid = 1'b0;
        data_out_ready = 1'b0;
        lcg_state = SEED;
        held_out = '0;
        held_valid = 1'b0;
        cycle_cnt = 0;
        accept_cycle = 0;
        check_cnt = 0;
        error_cnt = 0;
        vec_done = 0;
        none_cnt = 0;
        few_cnt = 0;
        many_cnt = 0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        compare_value("weight_ready", 0, weight_ready, 1);
        compare_value("data_out_valid", 0, data_out_valid, 0);
        for (int r = 0; r < VEC_LEN; r++) begin
            compare_value("data_out", r, longint'(data_out[r]), 0);
        end
        repeat (3) begin                               // no matrix yet, so no data either
            compare_value("data_in_ready", 0, data_in_ready, 0);
            @(posedge clk);
            #2;
        end
        load_weights();
        for (int v = 0; v < NUM_VECTORS; v++) begin
            if (v % 8 == 3) begin
                load_weights();
            end
            send_vector(v % 8 == 7);
            collect_result();
        end
        @(posedge clk);
        #2;
        if (expect_q.size() != 0) begin
            error_cnt++;
            $display("%0d predicted results never came out", expect_q.size());
        end
        if (none_cnt == 0 || few_cnt == 0 || many_cnt == 0) begin
            error_cnt++;
            $display("vector mix incomplete: %0d without, %0d with few, %0d with many outliers",
                     none_cnt, few_cnt, many_cnt);
        end
        finish_run(1'b0);
    end

endmodule

// ==== tb.f ====
llm_int_pkg.sv
outlier_scatter.sv
weight_store.sv
row_mac.sv
mixed_gather.sv
linear_ctrl.sv
llm_int_linear.sv
tb_llm_int_linear.sv

// ==== run.sh ====
#!/bin/bash
# compile and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_llm_int_linear -f tb.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
